// File: build.f
source/sensor_pkg.sv
source/pixel_if.sv
source/cmd_deser.sv
source/status_gen.sv
source/status_router.sv
source/sens_pixel_io.sv
source/sens_gamma.sv
source/sensor_channel.sv
verif/tb_checker.sv
verif/tb_sensor_channel.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f build.f --top-module tb_sensor_channel -o sim_tb || exit 1
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/tb_sensor_channel.sv
/*
 * sensor channel testbench with clock, reset, stimulus table and driver loop
 */
`timescale 1ns/1ps

module tb_sensor_channel;
    localparam int k_cmd = 0, k_frame = 1, k_load = 2, k_ack = 3;
    localparam int n_rows = 22;

    logic        mclk, reset, cmd_stb, sns_vact, sns_hact, status_start;
    logic [7:0]  cmd_ad;
    logic [11:0] sns_pxd;
    logic [7:0]  pxd_out, status_ad;
    logic        hact_out, sof_out, eof_out, status_rq;
    int          check_errors, status_pending, wait_errors;
    logic [31:0] rng;

    // command rows hold address and data in row_a and row_b
    // frame rows hold lines, pixels per line and seed
    int row_kind [0:n_rows-1] = '{k_cmd, k_frame, k_load, k_cmd, k_frame, k_cmd, k_frame,
        k_cmd, k_frame, k_cmd, k_frame, k_cmd, k_cmd, k_frame, k_cmd, k_cmd, k_ack, k_ack,
        k_cmd, k_cmd, k_ack, k_ack};
    int row_a [0:n_rows-1] = '{'h330, 3, 0, 'h338, 2, 'h338, 2, 'h333, 2, 'h333, 2,
        'h340, 'h33c, 2, 'h331, 'h339, 0, 0, 'h339, 'h331, 0, 0};
    int row_b [0:n_rows-1] = '{1, 6, 0, 'hc, 8, 'h8, 8, 5, 9, 0, 9,
        0, 0, 7, 'h15, 'h2a, 0, 0, 'h07, 'h3c, 0, 0};
    int row_c [0:n_rows-1] = '{0, 1, 0, 0, 2, 0, 3, 0, 4, 0, 5,
        0, 0, 6, 0, 0, 0, 0, 0, 0, 0, 0};

    sensor_channel i_dut (.*);

    tb_checker i_checker (
        .mclk, .reset, .cmd_ad, .cmd_stb, .sns_vact, .sns_hact, .sns_pxd,
        .pxd_out, .hact_out, .sof_out, .eof_out, .status_ad, .status_rq, .status_start,
        .errors (check_errors), .pending (status_pending)
    );

    always #5 mclk = ~mclk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [7:0] table_fill(input logic [8:0] a);
        return (a[7:0] * 8'd13 + 8'd7) ^ (a[8] ? 8'ha5 : 8'h00);   // page 1 differs
    endfunction

    task automatic send_cmd(input logic [15:0] a, input logic [31:0] d);
        @(posedge mclk);
        cmd_stb <= 1'b1;
        cmd_ad  <= a[7:0];
        @(posedge mclk);
        cmd_stb <= 1'b0;
        cmd_ad  <= a[15:8];
        for (int i = 0; i < 4; i++) begin
            @(posedge mclk);
            cmd_ad <= d[8*i +: 8];                    // D0 first
        end
        @(posedge mclk);
        cmd_ad <= 8'h00;
        repeat (11) @(posedge mclk);                  // idle gap
    endtask

    task automatic load_table();
        logic [8:0] a;
        send_cmd(16'h33a, 32'd0);                     // taddr = 0
        for (int i = 0; i < 256; i++) begin
            a = 9'(2 * i);
            send_cmd(16'h33b, {16'h0, table_fill(a + 9'd1), table_fill(a)});
        end
    endtask

    task automatic drive_frame(input int lines, input int ppl, input int seed);
        int n;
        rng = 32'd93154 ^ seed;
        @(posedge mclk);
        sns_vact <= 1'b1;
        repeat (3) @(posedge mclk);
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < ppl; p++) begin
                rng = xorshift(rng);
                sns_hact <= 1'b1;
                sns_pxd  <= rng[11:0];
                @(posedge mclk);
            end
            sns_hact <= 1'b0;
            sns_pxd  <= 12'h000;
            repeat (8) @(posedge mclk);               // line gap
        end
        sns_vact <= 1'b0;
        n = 0;
        do begin
            @(posedge mclk);
            n++;
        end while (n < 30 && !eof_out);
        if (!eof_out) begin
            $display("timeout: no end of frame seen on eof_out");
            wait_errors++;
        end
        repeat (6) @(posedge mclk);
    endtask

    task automatic ack_status();
        int n;
        n = 0;
        do begin
            @(posedge mclk);
            n++;
        end while (n < 200 && !status_rq);
        if (!status_rq) begin
            $display("timeout: status_rq never rose for a status acknowledge");
            wait_errors++;
        end else begin
            rng = xorshift(rng);
            repeat (rng[2:0]) @(posedge mclk);        // random start delay
            status_start <= 1'b1;
            @(posedge mclk);
            status_start <= 1'b0;
        end
    endtask

    initial begin
        int n;
        mclk = 1'b0;
        reset = 1'b1;
        {cmd_stb, sns_vact, sns_hact, status_start} = 4'b0;
        cmd_ad = 8'h00;
        sns_pxd = 12'h000;
        wait_errors = 0;
        rng = 32'd93154;
        repeat (2) @(posedge mclk);
        reset <= 1'b0;
        repeat (3) @(posedge mclk);
        for (int r = 0; r < n_rows; r++) begin
            case (row_kind[r])
                k_cmd:   send_cmd(16'(row_a[r]), 32'(row_b[r]));
                k_frame: drive_frame(row_a[r], row_b[r], row_c[r]);
                k_load:  load_table();
                default: ack_status();
            endcase
        end
        n = 0;
        do begin
            @(posedge mclk);
            n++;
        end while (n < 300 && status_pending != 0);
        if (status_pending != 0) begin
            $display("timeout: %0d status packets never arrived", status_pending);
            wait_errors++;
        end
        repeat (10) @(posedge mclk);
        $display("errors: %0d check, %0d wait", check_errors, wait_errors);
        if (check_errors == 0 && wait_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: verif/tb_checker.sv
/*
 * testbench checker with pixel output model, gamma table and register shadow,
 * status packet collection and error count
 */
`timescale 1ns/1ps

module tb_checker (
    input  logic        mclk,
    input  logic        reset,
    input  logic [7:0]  cmd_ad,
    input  logic        cmd_stb,
    input  logic        sns_vact,
    input  logic        sns_hact,
    input  logic [11:0] sns_pxd,
    input  logic [7:0]  pxd_out,
    input  logic        hact_out,
    input  logic        sof_out,
    input  logic        eof_out,
    input  logic [7:0]  status_ad,
    input  logic        status_rq,
    input  logic        status_start,
    output int          errors,
    output int          pending
);
    logic [7:0]              tab [0:511];      // shadow of the gamma table
    logic [8:0]              taddr;
    sensor_pkg::gamma_mode_t mode;
    logic                    io_en;
    logic [15:0]             width, rem;       // regenerated line cycles left
    logic                    vact_p, hact_p, sof_pend;
    logic [15:0]             lines, last_lines;
    logic [9:0]              frames, twrites;
    logic [15:0]             gframes;          // frames seen by gamma
    logic [7:0]              cbuf [0:5];
    int                      ccnt;
    logic [31:0]             exp_pkt [0:1];    // pixel io at index 0 and gamma at 1
    logic                    exp_v [0:1];
    int                      rcnt;
    logic [7:0]              raddr;
    logic [31:0]             rword;
    logic                    eh, es, ee, vr, vf, hr;
    logic                    pv [0:3], ph [0:3], ps [0:3], pe [0:3];   // 4-cycle pipe
    logic [7:0]              pp [0:3];

    assign pending = int'(exp_v[0]) + int'(exp_v[1]);

    task automatic report(input string name, input logic [31:0] e, input logic [31:0] g);
        $display("CHECK FAILED %s expected %h got %h", name, e, g);
        errors++;
    endtask

    // payload bytes 4 to 1 with seq above status bits 1:0 in byte 1
    function automatic logic [31:0] pkt_word(input logic [25:0] s, input logic [5:0] seq);
        logic [7:0] b1, b2, b3, b4;
        b1 = {seq, s[1:0]};
        b2 = s[9:2];
        b3 = s[17:10];
        b4 = s[25:18];
        return {b4, b3, b2, b1};
    endfunction

    task automatic apply_cmd(input logic [15:0] a, input logic [31:0] d);
        sensor_pkg::gamma_word_u cw;
        logic [15:0]             off;
        cw = d;
        if ((a & sensor_pkg::sensio_mask) == sensor_pkg::sensio_addr) begin
            off = a - sensor_pkg::sensio_addr;
            if (off == 0) io_en = d[0];
            if (off == 3) width = d[15:0];
            if (off == 1) begin
                exp_pkt[0] = pkt_word({frames, last_lines}, d[5:0]);
                exp_v[0] = 1'b1;
            end
        end else if ((a & sensor_pkg::gamma_mask) == sensor_pkg::gamma_addr) begin
            off = a - sensor_pkg::gamma_addr;
            if (off == 0) mode = cw.mode;
            if (off == 2) taddr = d[8:0];
            if (off == 3) begin
                tab[taddr] = cw.tbl.entry_lo;            // pair of entries
                tab[taddr + 9'd1] = cw.tbl.entry_hi;
                taddr = taddr + 9'd2;
                twrites++;
            end
            if (off == 1) begin
                exp_pkt[1] = pkt_word({twrites, gframes}, d[5:0]);
                exp_v[1] = 1'b1;
            end
        end
    endtask

    task automatic check_packet(input logic [7:0] a, input logic [31:0] w);
        int k;
        k = (a == 8'h31) ? 0 : (a == 8'h32) ? 1 : -1;
        if (k < 0 || !exp_v[k]) begin
            $display("unexpected status packet with address byte %h", a);
            errors++;
        end else begin
            if (w !== exp_pkt[k]) report("status_ad payload", exp_pkt[k], w);
            exp_v[k] = 1'b0;
        end
    endtask

    initial errors = 0;

    always @(posedge mclk) begin
        if (reset) begin
            {io_en, vact_p, hact_p, sof_pend} = 4'b0;
            {width, rem, lines, last_lines, gframes} = '0;
            {frames, twrites, taddr} = '0;
            mode = '0;
            ccnt = 0;
            rcnt = 0;
            exp_v[0] = 1'b0;
            exp_v[1] = 1'b0;
            for (int i = 0; i < 4; i++) pv[i] = 1'b0;
        end else begin
            if (pv[3]) begin                                  // pixel seen 4 cycles ago
                if (hact_out !== ph[3]) report("hact_out", ph[3], hact_out);
                if (sof_out !== ps[3]) report("sof_out", ps[3], sof_out);
                if (eof_out !== pe[3]) report("eof_out", pe[3], eof_out);
                if (ph[3] && pxd_out !== pp[3]) report("pxd_out", pp[3], pxd_out);
            end
            if (status_rq && !exp_v[0] && !exp_v[1]) begin
                $display("status_rq is high while no status request is pending");
                errors++;
            end
            if (rcnt == 0) begin
                if (status_start && status_rq) begin
                    raddr = status_ad;                        // address byte
                    rcnt = 1;
                end
            end else begin
                rword = {status_ad, rword[31:8]};
                rcnt++;
                if (rcnt == 5) begin
                    rcnt = 0;
                    check_packet(raddr, rword);
                end
            end
            if (cmd_stb) begin
                cbuf[0] = cmd_ad;
                ccnt = 1;
            end else if (ccnt > 0) begin
                cbuf[ccnt] = cmd_ad;
                ccnt++;
                if (ccnt == 6) begin
                    ccnt = 0;
                    apply_cmd({cbuf[1], cbuf[0]}, {cbuf[5], cbuf[4], cbuf[3], cbuf[2]});
                end
            end
            vr = sns_vact && !vact_p;
            vf = !sns_vact && vact_p;
            hr = sns_hact && !hact_p;
            if (width == 0) begin
                eh = sns_hact;
            end else begin
                if (hr) rem = width;                          // line restarts the count
                eh = (rem != 0);
                if (rem != 0) rem--;
            end
            es = eh && (sof_pend || vr);
            if (es) sof_pend = 1'b0;
            else if (vr) sof_pend = 1'b1;
            ee = vf;
            if (vr) lines = {15'd0, hr};
            else if (hr) lines++;
            if (vf) begin
                last_lines = lines;
                frames++;
            end
            if (io_en && vf) gframes++;
            for (int i = 3; i > 0; i--) begin
                {pv[i], ph[i], ps[i], pe[i], pp[i]} = {pv[i-1], ph[i-1], ps[i-1], pe[i-1], pp[i-1]};
            end
            pv[0] = 1'b1;
            ph[0] = io_en && eh;
            ps[0] = io_en && es;
            pe[0] = io_en && ee;
            pp[0] = mode.en ? tab[{mode.page, sns_pxd[11:4]}] : sns_pxd[11:4];
            vact_p = sns_vact;
            hact_p = sns_hact;
        end
    end

endmodule

// File: source/sensor_channel.sv
/*
 * sensor channel top: capture, gamma, status router
 */
`timescale 1ns/1ps

module sensor_channel (
    input  logic        mclk,
    input  logic        reset,
    input  logic [7:0]  cmd_ad,        // AL, AH, D0..D3
    input  logic        cmd_stb,       // with AL only
    input  logic        sns_vact,
    input  logic        sns_hact,
    input  logic [11:0] sns_pxd,
    output logic [7:0]  pxd_out,
    output logic        hact_out,
    output logic        sof_out,
    output logic        eof_out,
    output logic [7:0]  status_ad,
    output logic        status_rq,
    input  logic        status_start
);
    logic [7:0] io_status_ad, gm_status_ad;
    logic       io_status_rq, gm_status_rq;
    logic       io_status_start, gm_status_start;

    pixel_if #(.pxd_w(sensor_pkg::pxd_in_w)) pix_cap ();   // capture to gamma

    sens_pixel_io i_sens_pixel_io (
        .mclk, .reset, .cmd_ad, .cmd_stb, .sns_vact, .sns_hact, .sns_pxd,
        .status_ad    (io_status_ad),
        .status_rq    (io_status_rq),
        .status_start (io_status_start),
        .pix          (pix_cap)
    );

    sens_gamma i_sens_gamma (
        .mclk, .reset, .cmd_ad, .cmd_stb,
        .status_start (gm_status_start),
        .pix_in       (pix_cap),
        .pxd_out, .hact_out, .sof_out, .eof_out,
        .status_ad    (gm_status_ad),
        .status_rq    (gm_status_rq)
    );

    status_router i_status_router (
        .mclk, .reset,
        .db_in0 (io_status_ad), .rq_in0 (io_status_rq), .start_in0 (io_status_start),
        .db_in1 (gm_status_ad), .rq_in1 (gm_status_rq), .start_in1 (gm_status_start),
        .db_out (status_ad), .rq_out (status_rq), .start_out (status_start)
    );

endmodule

// File: source/sens_gamma.sv
/*
 * gamma conversion 12 to 8 bits, two-page lookup table,
 * table load, mode register and status
 */
`timescale 1ns/1ps

module sens_gamma (
    input  logic                             mclk,
    input  logic                             reset,
    input  logic [7:0]                       cmd_ad,
    input  logic                             cmd_stb,
    input  logic                             status_start,
    pixel_if.sink                            pix_in,
    output logic [sensor_pkg::pxd_out_w-1:0] pxd_out,
    output logic                             hact_out,
    output logic                             sof_out,
    output logic                             eof_out,
    output logic [7:0]                       status_ad,
    output logic                             status_rq
);
    localparam int msb = sensor_pkg::pxd_in_w - 1;

    logic                              cmd_we;
    logic [2:0]                        cmd_reg;
    logic [sensor_pkg::cmd_data_w-1:0] cmd_data;
    sensor_pkg::gamma_word_u           cw;          // same word, two views
    sensor_pkg::gamma_mode_t           mode;
    logic [7:0]                        gtab [0:511];  // {page, pxd[11:4]}
    logic [8:0]                        taddr;
    logic                              tdata_we;
    logic [9:0]                        table_writes;
    logic [15:0]                       frames_passed;
    logic [7:0]                        lut_q, pxd_q;
    logic                              hact_q, sof_q, eof_q;

    cmd_deser #(.base_addr(sensor_pkg::gamma_addr), .addr_mask(sensor_pkg::gamma_mask))
        i_cmd_deser (.mclk, .reset, .cmd_ad, .cmd_stb, .cmd_we, .cmd_reg, .cmd_data);

    status_gen #(.status_reg(sensor_pkg::gamma_status_reg)) i_status_gen (
        .mclk, .reset, .status_start, .status_ad, .status_rq,
        .send   (cmd_we && cmd_reg == sensor_pkg::gamma_status),
        .seq    (cmd_data[5:0]),
        .status ({table_writes, frames_passed})
    );

    assign cw       = cmd_data;
    assign tdata_we = cmd_we && cmd_reg == sensor_pkg::gamma_tdata;

    always_ff @(posedge mclk) begin
        if (tdata_we) begin
            gtab[taddr]        <= cw.tbl.entry_lo;    // two entries per write
            gtab[taddr + 9'd1] <= cw.tbl.entry_hi;
        end
        lut_q   <= gtab[{mode.page, pix_in.pxd[msb -: 8]}];
        pxd_q   <= pix_in.pxd[msb -: 8];
        pxd_out <= mode.en ? lut_q : pxd_q;           // bypass keeps top 8 bits
    end

    always_ff @(posedge mclk) begin
        if (reset) begin
            mode  <= '0;                              // en = 0 after reset
            taddr <= 9'd0;
            table_writes  <= 10'd0;
            frames_passed <= 16'd0;
            {hact_q, sof_q, eof_q, hact_out, sof_out, eof_out} <= 6'b0;
        end else begin
            {hact_q, sof_q, eof_q} <= {pix_in.hact, pix_in.sof, pix_in.eof};
            {hact_out, sof_out, eof_out} <= {hact_q, sof_q, eof_q};  // match table latency
            if (cmd_we && cmd_reg == sensor_pkg::gamma_ctrl) mode <= cw.mode;
            if (cmd_we && cmd_reg == sensor_pkg::gamma_taddr)
                taddr <= cmd_data[8:0];
            else if (tdata_we)
                taddr <= taddr + 9'd2;
            if (tdata_we) table_writes <= table_writes + 10'd1;
            if (pix_in.eof) frames_passed <= frames_passed + 16'd1;
        end
    end

endmodule

// File: source/sens_pixel_io.sv
/*
 * parallel sensor capture: frame markers, hact regeneration,
 * line and frame counters, control and status registers
 */
`timescale 1ns/1ps

module sens_pixel_io (
    input  logic        mclk,
    input  logic        reset,
    input  logic [7:0]  cmd_ad,
    input  logic        cmd_stb,
    input  logic        sns_vact,
    input  logic        sns_hact,
    input  logic [11:0] sns_pxd,
    output logic [7:0]  status_ad,
    output logic        status_rq,
    input  logic        status_start,
    pixel_if.source     pix
);
    logic                               cmd_we;
    logic [2:0]                         cmd_reg;
    logic [sensor_pkg::cmd_data_w-1:0]  cmd_data;
    logic                               en;           // capture enable
    logic [sensor_pkg::width_w-1:0]     width, hcnt;  // regenerated line length
    logic [sensor_pkg::pxd_in_w-1:0]    pxd_r;
    logic                               vact_r, vact_d, hact_r, hact_d;
    logic                               vact_rise, vact_fall, hact_rise, hact_o, sof_o;
    logic                               sof_pend;
    logic [15:0]                        line_cnt, last_lines;
    logic [9:0]                         frame_cnt;

    cmd_deser #(.base_addr(sensor_pkg::sensio_addr), .addr_mask(sensor_pkg::sensio_mask))
        i_cmd_deser (.mclk, .reset, .cmd_ad, .cmd_stb, .cmd_we, .cmd_reg, .cmd_data);

    status_gen #(.status_reg(sensor_pkg::sensio_status_reg)) i_status_gen (
        .mclk, .reset, .status_start, .status_ad, .status_rq,
        .send   (cmd_we && cmd_reg == sensor_pkg::sensio_status),
        .seq    (cmd_data[5:0]),
        .status ({frame_cnt, last_lines})
    );

    assign vact_rise = vact_r && !vact_d;
    assign vact_fall = !vact_r && vact_d;
    assign hact_rise = hact_r && !hact_d;
    assign hact_o = (width == '0) ? hact_r : (hact_rise || hcnt != '0);
    assign sof_o  = hact_o && (sof_pend || vact_rise);    // first pixel of frame

    always_ff @(posedge mclk) begin
        pxd_r    <= sns_pxd;
        pix.pxd  <= pxd_r;
        if (reset) begin
            {vact_r, vact_d, hact_r, hact_d} <= 4'b0;
            {pix.hact, pix.sof, pix.eof, en, sof_pend} <= 5'b0;
            {width, hcnt, line_cnt, last_lines, frame_cnt} <= '0;
        end else begin
            {vact_r, vact_d, hact_r, hact_d} <= {sns_vact, vact_r, sns_hact, hact_r};
            pix.hact <= en && hact_o;
            pix.sof  <= en && sof_o;
            pix.eof  <= en && vact_fall;
            if (cmd_we && cmd_reg == sensor_pkg::sensio_ctrl) en <= cmd_data[0];
            if (cmd_we && cmd_reg == sensor_pkg::sensio_width) width <= cmd_data[15:0];
            if (width != '0 && hact_rise) hcnt <= width - 1'b1;
            else if (hcnt != '0) hcnt <= hcnt - 1'b1;
            if (sof_o) sof_pend <= 1'b0;
            else if (vact_rise) sof_pend <= 1'b1;
            // counters run whether or not capture is enabled
            if (vact_rise) line_cnt <= {15'd0, hact_rise};
            else if (hact_rise) line_cnt <= line_cnt + 16'd1;
            if (vact_fall) begin
                last_lines <= line_cnt;
                frame_cnt  <= frame_cnt + 10'd1;
            end
        end
    end

endmodule

// File: source/status_router.sv
/*
 * two-input round-robin status packet arbiter that never interleaves packets
 */
`timescale 1ns/1ps

module status_router (
    input  logic       mclk,
    input  logic       reset,
    input  logic [7:0] db_in0,
    input  logic       rq_in0,
    output logic       start_in0,
    input  logic [7:0] db_in1,
    input  logic       rq_in1,
    output logic       start_in1,
    output logic [7:0] db_out,
    output logic       rq_out,
    input  logic       start_out
);
    logic       gnt;       // grant held until packet tail ends
    logic       sel;       // granted source
    logic       last;      // source served last
    logic [2:0] tail;      // payload bytes still to pass
    logic       pick;
    logic       cur;
    logic       busy;

    assign pick = (rq_in0 && rq_in1) ? ~last : rq_in1;
    assign cur  = gnt ? sel : pick;              // zero latency when idle
    assign busy = (tail != 3'd0);

    assign db_out    = cur ? db_in1 : db_in0;
    assign rq_out    = !busy && (cur ? rq_in1 : rq_in0);
    assign start_in0 = start_out && !busy && !cur;
    assign start_in1 = start_out && !busy && cur;

    always_ff @(posedge mclk) begin
        if (reset) begin
            gnt  <= 1'b0;
            sel  <= 1'b0;
            last <= 1'b0;
            tail <= 3'd0;
        end else begin
            if (!gnt && (rq_in0 || rq_in1)) begin
                gnt <= 1'b1;                     // freeze choice for the packet
                sel <= pick;
            end
            if (start_out && !busy) begin
                tail <= 3'd4;
                last <= cur;
            end else if (busy) begin
                tail <= tail - 3'd1;
                if (tail == 3'd1)
                    gnt <= 1'b0;                 // back to idle after byte 4
            end
        end
    end

    // a start only acknowledges a forwarded request
    a_start_on_rq: assert property (@(posedge mclk) disable iff (reset)
        start_out |-> rq_out);

endmodule

// File: source/status_gen.sv
/*
 * 5-byte status packet source, request/start handshake
 */
`timescale 1ns/1ps

module status_gen #(
    parameter logic [7:0] status_reg = 8'h00
) (
    input  logic                          mclk,
    input  logic                          reset,
    input  logic                          send,
    input  logic [sensor_pkg::seq_w-1:0]  seq,
    input  logic [sensor_pkg::status_w-1:0] status,
    input  logic                          status_start,
    output logic [7:0]                    status_ad,
    output logic                          status_rq
);
    logic [sensor_pkg::seq_w-1:0]    seq_r;
    logic [sensor_pkg::status_w-1:0] status_r;
    logic                            pend;     // request waiting for start
    logic [2:0]                      bcnt;     // 0 - address byte, 1..4 payload
    logic [31:0]                     sh;       // payload bytes, LSB first

    assign status_rq = pend && (bcnt == 3'd0);   // held off during own payload
    assign status_ad = (bcnt == 3'd0) ? status_reg : sh[7:0];

    always_ff @(posedge mclk) begin
        if (reset) begin
            pend <= 1'b0;
            bcnt <= 3'd0;
        end else begin
            if (send)
                pend <= 1'b1;                    // newer request wins
            else if (status_start)
                pend <= 1'b0;
            if (status_start)
                bcnt <= 3'd1;
            else if (bcnt != 3'd0)
                bcnt <= (bcnt == 3'd4) ? 3'd0 : bcnt + 3'd1;
        end
        if (send) begin
            seq_r    <= seq;                     // replaces a pending packet
            status_r <= status;
        end
        if (status_start)
            sh <= {status_r[25:2], seq_r, status_r[1:0]};
        else
            sh <= {8'h00, sh[31:8]};
    end

    a_start_on_rq: assert property (@(posedge mclk) disable iff (reset)
        status_start |-> status_rq);

endmodule

// File: source/cmd_deser.sv
/*
 * byte-serial command deserializer with address window decode
 */
`timescale 1ns/1ps

module cmd_deser #(
    parameter logic [sensor_pkg::cmd_addr_w-1:0] base_addr = '0,
    parameter logic [sensor_pkg::cmd_addr_w-1:0] addr_mask = '1
) (
    input  logic                            mclk,
    input  logic                            reset,
    input  logic [7:0]                      cmd_ad,
    input  logic                            cmd_stb,
    output logic                            cmd_we,
    output logic [2:0]                      cmd_reg,
    output logic [sensor_pkg::cmd_data_w-1:0] cmd_data
);
    logic [7:0]                        ad_r;       // registered byte
    logic                              stb_r;
    logic [2:0]                        cnt;        // 0 - idle, 1..5 next byte index
    logic [sensor_pkg::cmd_addr_w-1:0] addr_sr;
    logic [23:0]                       data_sr;    // D2, D1, D0
    logic                              hit;

    assign hit = (addr_sr & addr_mask) == (base_addr & addr_mask);

    always_ff @(posedge mclk) begin
        ad_r <= cmd_ad;
        if (reset) begin
            stb_r  <= 1'b0;
            cnt    <= 3'd0;
            cmd_we <= 1'b0;
        end else begin
            stb_r  <= cmd_stb;
            cmd_we <= (cnt == 3'd5) && hit;                  // D3 sits in ad_r now
            if (stb_r)
                cnt <= 3'd1;
            else if (cnt != 3'd0)
                cnt <= (cnt == 3'd5) ? 3'd0 : cnt + 3'd1;
        end
        if (stb_r) addr_sr[7:0] <= ad_r;                     // AL
        if (cnt == 3'd1) addr_sr[15:8] <= ad_r;              // AH
        if (cnt >= 3'd2 && cnt <= 3'd4) data_sr <= {ad_r, data_sr[23:8]};
        if (cnt == 3'd5) begin
            cmd_data <= {ad_r, data_sr};
            cmd_reg  <= addr_sr[2:0] & ~addr_mask[2:0];      // index below the mask
        end
    end

    // new command only after the previous one is fully assembled
    a_no_overlap: assert property (@(posedge mclk) disable iff (reset)
        stb_r |-> cnt == 3'd0);

endmodule

// File: source/pixel_if.sv
/*
 * pixel stream between capture and gamma: data, line active, frame markers
 */
`timescale 1ns/1ps

interface pixel_if #(
    parameter int pxd_w = sensor_pkg::pxd_in_w
) ();
    logic [pxd_w-1:0] pxd;      // pixel data
    logic             hact;     // line active, one pixel per cycle
    logic             sof;      // first pixel of frame
    logic             eof;      // single pulse after last line

    modport source (output pxd, hact, sof, eof);
    modport sink   (input  pxd, hact, sof, eof);

endinterface

// File: source/sensor_pkg.sv
/*
 * command and status widths, address windows and register indices,
 * pixel widths, gamma command word views
 */
package sensor_pkg;

    localparam int cmd_addr_w = 16;                           // AL, AH
    localparam int cmd_data_w = 32;                           // D0..D3, little-endian

    localparam logic [cmd_addr_w-1:0] sensio_addr = 'h330;    // pixel capture window
    localparam logic [cmd_addr_w-1:0] sensio_mask = 'h3f8;
    localparam logic [2:0] sensio_ctrl   = 3'd0;              // bit 0 enables capture
    localparam logic [2:0] sensio_status = 3'd1;
    localparam logic [2:0] sensio_width  = 3'd3;              // 0 - pass hact through
    localparam logic [7:0] sensio_status_reg = 8'h31;

    localparam logic [cmd_addr_w-1:0] gamma_addr = 'h338;     // gamma window
    localparam logic [cmd_addr_w-1:0] gamma_mask = 'h3fc;
    localparam logic [2:0] gamma_ctrl   = 3'd0;
    localparam logic [2:0] gamma_status = 3'd1;
    localparam logic [2:0] gamma_taddr  = 3'd2;
    localparam logic [2:0] gamma_tdata  = 3'd3;
    localparam logic [7:0] gamma_status_reg = 8'h32;

    localparam int status_w  = 26;
    localparam int seq_w     = 6;
    localparam int pxd_in_w  = 12;
    localparam int pxd_out_w = 8;
    localparam int width_w   = 16;

    typedef struct packed {
        logic [25:0] unused;
        logic        trig;                                    // kept, no function here
        logic        repet;                                   // kept, no function here
        logic        en;
        logic        page;
        logic [1:0]  bayer;
    } gamma_mode_t;

    typedef struct packed {
        logic [15:0] unused;
        logic [7:0]  entry_hi;                                // goes to taddr + 1
        logic [7:0]  entry_lo;                                // goes to taddr
    } gamma_tbl_t;

    typedef union packed {
        gamma_mode_t mode;                                    // gamma_ctrl writes
        gamma_tbl_t  tbl;                                     // gamma_tdata writes
    } gamma_word_u;

endpackage
